/* test/pkt_scheduler_stimulus.txt */
# Columns: op then hex operands. W cmd data, R cmd expected, I core count,
# L core slot, C interface lines, H interface hash core slot drop, N interface hash cycles
R 20000000 0
R 20000001 0
R 2000000f fefefefe
R 20000002 fefefefe
R 20000003 0
# Incoming is masked by enabled
W a0000000 3c
W a0000001 ff
R 20000001 3c
R 20000000 3c
W a0000000 24
R 20000001 24
R 20000000 24
# Core 5 with four slots
I 5 4
R 20000053 4
H 0 a5a14321 5 1 0
R 20000053 3
H 1 3c157777 5 2 0
R 20000053 2
H 2 dead5f00 5 3 0
H 0 0f0f4f0f 5 4 0
R 20000053 0
# Drops with the buffer at or above the limit
C 1 e00
H 1 00014000 5 0 1
R 60000012 1
C 1 f00
H 1 a5a14321 5 0 1
R 60000012 2
R 60000002 0
R 60000032 fefefefe
R 6000000f fefefefe
W e0000003 100
C 2 100
H 2 0f0f4f0f 5 0 1
R 60000022 1
C 1 0
C 2 0
# Waiting hash, then a released slot
N 0 a5a14321 10
L 5 9
H 0 a5a14321 5 9 0
R 20000053 0
# Flush empties the queue
I 5 6
R 20000053 6
W a0000002 20
R 20000053 0
N 1 dead5f00 10
# Core 2 allocates until it leaves the incoming mask
I 2 3
H 2 00008000 2 1 0
R 20000023 2
W a0000001 20
R 20000001 20
N 2 00008000 8

/* build.f */
+incdir+include
design/sched_pkg.sv
design/slot_keeper.sv
design/slot_pool.sv
design/host_cmd_regs.sv
design/desc_allocator.sv
design/pkt_scheduler.sv
test/pkt_scheduler_assertions.sv
test/pkt_scheduler_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the packet scheduler testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module pkt_scheduler_tb -f build.f -o pkt_scheduler_sim

./obj_dir/pkt_scheduler_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi

/* test/pkt_scheduler_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module pkt_scheduler_tb import sched_pkg::*; ();

  localparam string STIM_FILE = "test/pkt_scheduler_stimulus.txt";
  localparam int    WINDOW    = 24;

  logic                              clk = 1'b0;
  logic                              rst_r;
  host_word_t                        host_cmd;
  host_word_t                        host_cmd_wr_data;
  logic                              host_cmd_valid;
  host_word_t                        host_cmd_rd_data;
  logic                              slot_msg_valid;
  slot_msg_e                         slot_msg_type;
  core_id_t                          slot_msg_core;
  slot_t                             slot_msg_slot;
  line_count_t [`SCHED_IF_COUNT-1:0] rx_line_count;
  hash_t [`SCHED_IF_COUNT-1:0]       hash;
  if_mask_t                          hash_valid;
  if_mask_t                          hash_ready;
  if_mask_t                          desc_valid;
  core_id_t [`SCHED_IF_COUNT-1:0]    desc_core;
  slot_t [`SCHED_IF_COUNT-1:0]       desc_slot;
  if_mask_t                          desc_drop;

  // Reference model state
  core_mask_t  m_enabled;
  core_mask_t  m_income;
  line_count_t m_limit;
  line_count_t m_lines [`SCHED_IF_COUNT];
  host_word_t  m_drops [`SCHED_IF_COUNT];
  slot_t       m_queue [`SCHED_CORE_COUNT][$];

  int errors      = 0;
  int tests       = 0;
  int line_no     = 0;
  int cycle_count = 0;
  int cycle_limit = 100000;

  always #2 clk = ~clk;

  pkt_scheduler pkt_scheduler_i (.*);

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the scheduler stopped making progress", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic compare_word(input string what, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_slot(input string what, input slot_t got, input slot_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_core(input string what, input core_id_t got, input core_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is core %0d, expected core %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // File values must agree with the model before the DUT is judged
  task automatic check_file(input string what, input host_word_t file_val,
                            input host_word_t model_val);
    if (file_val !== model_val) begin
      errors++;
      $display("Line %0d gives %s %h, but the reference model computes %h",
               line_no, what, file_val, model_val);
    end
  endtask

  function automatic int count_ops();
    int    fd;
    int    count;
    string text;
    count = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        if (text.len() > 0 && text[0] != "#" && text[0] != "\n") count++;
      end
      $fclose(fd);
    end
    return count;
  endfunction

  task automatic model_write(input host_word_t cmd, input host_word_t data);
    if (!cmd[30]) begin
      case (cmd[3:0])
        4'd0: begin
          m_enabled = core_mask_t'(data);
          m_income  = m_income & m_enabled;
        end
        4'd1: m_income = core_mask_t'(data) & m_enabled;
        4'd2: begin
          for (int k = 0; k < `SCHED_CORE_COUNT; k++) begin
            if (data[k]) m_queue[k].delete();
          end
        end
        default: ;
      endcase
    end else if (cmd[3:0] == 4'd3) begin
      m_limit = line_count_t'(data);
    end
  endtask

  function automatic host_word_t model_read(input host_word_t cmd);
    logic [24:0] idx;
    idx = cmd[28:4];
    if (cmd[30]) begin
      if (cmd[3:0] == 4'd2 && idx < `SCHED_IF_COUNT) return m_drops[if_id_t'(idx)];
    end else begin
      if (cmd[3:0] == 4'd0) return host_word_t'(m_enabled);
      if (cmd[3:0] == 4'd1) return host_word_t'(m_income);
      if (cmd[3:0] == 4'd3) return host_word_t'(m_queue[core_id_t'(idx)].size());
    end
    return 32'hFEFEFEFE;
  endfunction

  task automatic model_init(input core_id_t core, input host_word_t count);
    m_queue[core].delete();
    for (int k = 1; k <= int'(count) && k <= `SCHED_SLOT_COUNT; k++) begin
      m_queue[core].push_back(slot_t'(k));
    end
  endtask

  task automatic host_write(input host_word_t cmd, input host_word_t data);
    host_cmd         = cmd;
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // Readback is valid two edges after the command
  task automatic host_read(input host_word_t cmd, output host_word_t data);
    host_cmd       = cmd;
    host_cmd_valid = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    @(negedge clk);
    data = host_cmd_rd_data;
  endtask

  task automatic slot_message(input slot_msg_e kind, input core_id_t core, input slot_t value);
    slot_msg_type  = kind;
    slot_msg_core  = core;
    slot_msg_slot  = value;
    slot_msg_valid = 1'b1;
    @(negedge clk);
    slot_msg_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic offer_hash(input if_id_t ifc, input hash_t h, input host_word_t f_core,
                            input host_word_t f_slot, input host_word_t f_drop);
    core_id_t core;
    slot_t    exp_slot;
    logic     exp_drop;
    logic     seen;
    core     = core_id_t'(h[`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)]);
    exp_slot = '0;
    if (m_income[core] && m_queue[core].size() > 0) begin
      exp_drop = 1'b0;
      exp_slot = m_queue[core].pop_front();
    end else if (m_lines[ifc] >= m_limit) begin
      exp_drop = 1'b1;
      m_drops[ifc]++;
    end else begin
      errors++;
      $display("Line %0d expects a descriptor, but the reference model predicts a stall",
               line_no);
      return;
    end
    check_file("core", f_core, host_word_t'(core));
    check_file("drop flag", f_drop, host_word_t'(exp_drop));
    if (!exp_drop) check_file("slot", f_slot, host_word_t'(exp_slot));
    hash[ifc]       = h;
    hash_valid[ifc] = 1'b1;
    seen            = 1'b0;
    for (int k = 0; k < WINDOW && !seen; k++) begin
      @(negedge clk);
      seen = desc_valid[ifc];
    end
    if (!seen) begin
      errors++;
      $display("No descriptor came out on interface %0d within %0d cycles", ifc, WINDOW);
    end else begin
      compare_core("desc_core", desc_core[ifc], core);
      compare_flag("desc_drop", desc_drop[ifc], exp_drop);
      compare_flag("hash_ready", hash_ready[ifc], 1'b1);
      if (!exp_drop) compare_slot("desc_slot", desc_slot[ifc], exp_slot);
    end
    // Pop happens on the coming edge together with desc_valid
    hash_valid[ifc] = 1'b0;
    @(negedge clk);
  endtask

  task automatic expect_stall(input if_id_t ifc, input hash_t h, input int window);
    core_id_t core;
    logic     seen;
    core = core_id_t'(h[`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)]);
    if ((m_income[core] && m_queue[core].size() > 0) || m_lines[ifc] >= m_limit) begin
      errors++;
      $display("Line %0d expects a stall, but the reference model predicts a descriptor",
               line_no);
      return;
    end
    hash[ifc]       = h;
    hash_valid[ifc] = 1'b1;
    seen            = 1'b0;
    for (int k = 0; k < window; k++) begin
      @(negedge clk);
      seen = seen | desc_valid[ifc] | hash_ready[ifc];
    end
    compare_flag("descriptor or hash pop while the hash waits", seen, 1'b0);
    hash_valid[ifc] = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    int          fd;
    int          errs_before;
    string       line;
    logic [7:0]  op;
    host_word_t  a;
    host_word_t  b;
    host_word_t  c;
    host_word_t  d;
    host_word_t  e;
    host_word_t  rd;
    host_word_t  exp;
    void'($urandom(3));
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    slot_msg_valid   = 1'b0;
    slot_msg_type    = slot_release;
    slot_msg_core    = '0;
    slot_msg_slot    = '0;
    rx_line_count    = '0;
    hash             = '0;
    hash_valid       = '0;
    rst_r            = 1'b1;
    m_enabled        = '0;
    m_income         = '0;
    m_limit          = line_count_t'(`SCHED_DROP_LIMIT_RESET);
    for (int k = 0; k < `SCHED_IF_COUNT; k++) begin
      m_lines[k] = '0;
      m_drops[k] = '0;
    end
    cycle_limit = count_ops() * (WINDOW + 8) + 50;
    repeat (2) @(negedge clk);
    rst_r = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        e = '0;
        errs_before = errors;
        void'($sscanf(line, "%c %h %h %h %h %h", op, a, b, c, d, e));
        case (op)
          "W": begin
            model_write(a, b);
            host_write(a, b);
          end
          "R": begin
            exp = model_read(a);
            check_file("read value", b, exp);
            host_read(a, rd);
            compare_word("host_cmd_rd_data", rd, exp);
          end
          "I": begin
            model_init(core_id_t'(a), b);
            slot_message(slot_init, core_id_t'(a), slot_t'(b));
          end
          "L": begin
            if (m_queue[core_id_t'(a)].size() < `SCHED_SLOT_COUNT) begin
              m_queue[core_id_t'(a)].push_back(slot_t'(b));
            end
            slot_message(slot_release, core_id_t'(a), slot_t'(b));
          end
          "C": begin
            m_lines[if_id_t'(a)]       = line_count_t'(b);
            rx_line_count[if_id_t'(a)] = line_count_t'(b);
            repeat (2) @(negedge clk);
          end
          "H": offer_hash(if_id_t'(a), b, c, d, e);
          "N": expect_stall(if_id_t'(a), b, int'(c));
          default: begin
            errors++;
            $display("Line %0d holds an unknown operation", line_no);
          end
        endcase
        tests++;
        $display("Test %0d, line %0d, op %c: %s", tests, line_no, op,
                 (errors == errs_before) ? "ok" : "failed");
        repeat ($urandom_range(2)) @(negedge clk);
      end
      $fclose(fd);
      $display("Tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/pkt_scheduler_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module pkt_scheduler_assertions import sched_pkg::*; (
  input logic     clk,
  input logic     rst_r,
  input if_mask_t hash_ready,
  input if_mask_t desc_valid
);

  // The hash pop is the descriptor strobe itself
  a_ready_is_valid: assert property (
    @(posedge clk) disable iff (rst_r) hash_ready == desc_valid
  ) else $error("hash_ready differs from desc_valid");

  // Only one interface is granted per cycle
  a_one_desc: assert property (
    @(posedge clk) disable iff (rst_r) $onehot0(desc_valid)
  ) else $error("more than one desc_valid in a cycle");

  a_quiet_after_reset: assert property (
    @(posedge clk) rst_r |=> desc_valid == '0
  ) else $error("desc_valid high in the cycle after reset");

endmodule

bind pkt_scheduler pkt_scheduler_assertions pkt_scheduler_assertions_i (
  .clk        (clk),
  .rst_r      (rst_r),
  .hash_ready (hash_ready),
  .desc_valid (desc_valid)
);

`default_nettype wire

/* design/pkt_scheduler.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module pkt_scheduler import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_r,
  input  host_word_t                        host_cmd,
  input  host_word_t                        host_cmd_wr_data,
  input  logic                              host_cmd_valid,
  output host_word_t                        host_cmd_rd_data,
  input  logic                              slot_msg_valid,
  input  slot_msg_e                         slot_msg_type,
  input  core_id_t                          slot_msg_core,
  input  slot_t                             slot_msg_slot,
  input  line_count_t [`SCHED_IF_COUNT-1:0] rx_line_count,
  input  hash_t [`SCHED_IF_COUNT-1:0]       hash,
  input  if_mask_t                          hash_valid,
  output if_mask_t                          hash_ready,
  output if_mask_t                          desc_valid,
  output core_id_t [`SCHED_IF_COUNT-1:0]    desc_core,
  output slot_t [`SCHED_IF_COUNT-1:0]       desc_slot,
  output if_mask_t                          desc_drop
);

  core_mask_t                       income_cores;
  core_mask_t                       slots_flush;
  if_mask_t                         almost_full;
  slot_t [`SCHED_CORE_COUNT-1:0]    slot_head;
  core_mask_t                       slot_avail;
  slot_t [`SCHED_CORE_COUNT-1:0]    slot_count;
  core_mask_t                       slot_pop;
  host_word_t [`SCHED_IF_COUNT-1:0] drop_count;

  // Enabled mask only matters inside the register block
  host_cmd_regs host_cmd_regs_i (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .rx_line_count    (rx_line_count),
    .slot_count       (slot_count),
    .drop_count       (drop_count),
    .enabled_cores    (),
    .income_cores     (income_cores),
    .slots_flush      (slots_flush),
    .almost_full      (almost_full),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  slot_pool slot_pool_i (
    .clk            (clk),
    .rst_r          (rst_r),
    .slot_msg_valid (slot_msg_valid),
    .slot_msg_type  (slot_msg_type),
    .slot_msg_core  (slot_msg_core),
    .slot_msg_slot  (slot_msg_slot),
    .slots_flush    (slots_flush),
    .slot_pop       (slot_pop),
    .slot_head      (slot_head),
    .slot_avail     (slot_avail),
    .slot_count     (slot_count)
  );

  desc_allocator desc_allocator_i (
    .clk          (clk),
    .rst_r        (rst_r),
    .hash_valid   (hash_valid),
    .hash         (hash),
    .almost_full  (almost_full),
    .income_cores (income_cores),
    .slot_head    (slot_head),
    .slot_avail   (slot_avail),
    .hash_ready   (hash_ready),
    .desc_valid   (desc_valid),
    .desc_core    (desc_core),
    .desc_slot    (desc_slot),
    .desc_drop    (desc_drop),
    .slot_pop     (slot_pop),
    .drop_count   (drop_count)
  );

endmodule

`default_nettype wire

/* design/desc_allocator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module desc_allocator import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_r,
  input  if_mask_t                          hash_valid,
  input  hash_t [`SCHED_IF_COUNT-1:0]       hash,
  input  if_mask_t                          almost_full,
  input  core_mask_t                        income_cores,
  input  slot_t [`SCHED_CORE_COUNT-1:0]     slot_head,
  input  core_mask_t                        slot_avail,
  output if_mask_t                          hash_ready,
  output if_mask_t                          desc_valid,
  output core_id_t [`SCHED_IF_COUNT-1:0]    desc_core,
  output slot_t [`SCHED_IF_COUNT-1:0]       desc_slot,
  output if_mask_t                          desc_drop,
  output core_mask_t                        slot_pop,
  output host_word_t [`SCHED_IF_COUNT-1:0]  drop_count
);

  if_mask_t req;
  logic     grant_valid;
  if_id_t   grant_id;
  core_id_t grant_core;
  if_id_t   last_r;
  logic     win_valid_r;
  if_mask_t win_mask_r;
  if_id_t   win_id_r;
  core_id_t win_core_r;
  logic     alloc;
  logic     drop;

  // Last cycle's winner is still being decided, so it sits out one round
  assign req = hash_valid & ~win_mask_r;

  // Round robin, starting after the last winner
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_id    = last_r;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      cand = (int'(last_r) + k) % `SCHED_IF_COUNT;
      if (!grant_valid && req[cand]) begin
        grant_valid = 1'b1;
        grant_id    = if_id_t'(cand);
      end
    end
  end

  assign grant_core = hash[grant_id][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];

  always_ff @(posedge clk) begin
    win_id_r   <= grant_id;
    win_core_r <= grant_core;
    if (rst_r) begin
      last_r      <= if_id_t'(`SCHED_IF_COUNT - 1);
      win_valid_r <= 1'b0;
      win_mask_r  <= '0;
    end else begin
      win_valid_r <= grant_valid;
      win_mask_r  <= grant_valid ? if_mask_t'(1) << grant_id : '0;
      if (grant_valid) last_r <= grant_id;
    end
  end

  // Allocate if the core takes traffic and has a slot, else drop if the buffer is filling
  assign alloc = win_valid_r && slot_avail[win_core_r] && income_cores[win_core_r];
  assign drop  = win_valid_r && !alloc && almost_full[win_id_r];

  assign desc_valid = (alloc || drop) ? win_mask_r : '0;
  assign hash_ready = desc_valid;
  assign desc_drop  = {`SCHED_IF_COUNT{drop}};
  assign slot_pop   = alloc ? core_mask_t'(1) << win_core_r : '0;

  always_comb begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      desc_core[i] = win_core_r;
      desc_slot[i] = slot_head[win_core_r];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_count <= '0;
    end else begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        if (drop && win_mask_r[i]) drop_count[i] <= drop_count[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/host_cmd_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module host_cmd_regs import sched_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_r,
  input  host_word_t                       host_cmd,
  input  host_word_t                       host_cmd_wr_data,
  input  logic                             host_cmd_valid,
  input  line_count_t [`SCHED_IF_COUNT-1:0]  rx_line_count,
  input  slot_t [`SCHED_CORE_COUNT-1:0]      slot_count,
  input  host_word_t [`SCHED_IF_COUNT-1:0]   drop_count,
  output core_mask_t                       enabled_cores,
  output core_mask_t                       income_cores,
  output core_mask_t                       slots_flush,
  output if_mask_t                         almost_full,
  output host_word_t                       host_cmd_rd_data
);

  logic                              cmd_wr_r;
  logic                              cmd_int_r;
  logic [3:0]                        cmd_reg_r;
  core_id_t                          cmd_core_r;
  if_id_t                            cmd_if_r;
  host_word_t                        wr_data_r;
  line_count_t [`SCHED_IF_COUNT-1:0] rx_line_count_r;
  line_count_t                       drop_limit;

  // Command stage, only writes to the scheduler are qualified
  always_ff @(posedge clk) begin
    cmd_int_r       <= host_cmd[30];
    cmd_reg_r       <= host_cmd[3:0];
    cmd_core_r      <= host_cmd[4 +: $bits(core_id_t)];
    cmd_if_r        <= host_cmd[4 +: $bits(if_id_t)];
    wr_data_r       <= host_cmd_wr_data;
    rx_line_count_r <= rx_line_count;
    if (rst_r) begin
      cmd_wr_r <= 1'b0;
    end else begin
      cmd_wr_r <= host_cmd_valid && host_cmd[31] && host_cmd[29];
    end
  end

  // Control registers; flush is a single cycle pulse
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= line_count_t'(`SCHED_DROP_LIMIT_RESET);
    end else begin
      slots_flush <= '0;
      if (cmd_wr_r) begin
        case ({cmd_int_r, cmd_reg_r})
          5'h00: begin
            // A disabled core cannot stay incoming
            enabled_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0];
            income_cores  <= income_cores & wr_data_r[`SCHED_CORE_COUNT-1:0];
          end
          5'h01: income_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0] & enabled_cores;
          5'h02: slots_flush  <= wr_data_r[`SCHED_CORE_COUNT-1:0];
          5'h13: drop_limit   <= wr_data_r[`SCHED_RX_LINES_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      almost_full[i] = rx_line_count_r[i] >= drop_limit;
    end
  end

  // Readback mux
  always_ff @(posedge clk) begin
    case ({cmd_int_r, cmd_reg_r})
      5'h00:   host_cmd_rd_data <= host_word_t'(enabled_cores);
      5'h01:   host_cmd_rd_data <= host_word_t'(income_cores);
      5'h03:   host_cmd_rd_data <= host_word_t'(slot_count[cmd_core_r]);
      5'h12: begin
        if (int'(cmd_if_r) < `SCHED_IF_COUNT) begin
          host_cmd_rd_data <= drop_count[cmd_if_r];
        end else begin
          host_cmd_rd_data <= 32'hFEFEFEFE;
        end
      end
      default: host_cmd_rd_data <= 32'hFEFEFEFE;
    endcase
  end

endmodule

`default_nettype wire

/* design/slot_pool.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module slot_pool import sched_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_r,
  input  logic                          slot_msg_valid,
  input  slot_msg_e                     slot_msg_type,
  input  core_id_t                      slot_msg_core,
  input  slot_t                         slot_msg_slot,
  input  core_mask_t                    slots_flush,
  input  core_mask_t                    slot_pop,
  output slot_t [`SCHED_CORE_COUNT-1:0] slot_head,
  output core_mask_t                    slot_avail,
  output slot_t [`SCHED_CORE_COUNT-1:0] slot_count
);

  core_mask_t msg_core_sel;
  core_mask_t release_r;
  core_mask_t init_r;
  slot_t      slot_r;

  assign msg_core_sel = core_mask_t'(1) << slot_msg_core;

  // Per-core strobes are registered to ease timing into the keepers
  always_ff @(posedge clk) begin
    slot_r <= slot_msg_slot;
    if (rst_r) begin
      release_r <= '0;
      init_r    <= '0;
    end else begin
      release_r <= (slot_msg_valid && slot_msg_type == slot_release) ? msg_core_sel : '0;
      init_r    <= (slot_msg_valid && slot_msg_type == slot_init) ? msg_core_sel : '0;
    end
  end

  for (genvar c = 0; c < `SCHED_CORE_COUNT; c++) begin : gen_keeper
    // A flush empties the queue just like reset
    slot_keeper slot_keeper_i (
      .clk            (clk),
      .rst_r          (rst_r || slots_flush[c]),
      .init_valid     (init_r[c]),
      .init_slots     (slot_r),
      .slot_in_valid  (release_r[c]),
      .slot_in        (slot_r),
      .slot_out_pop   (slot_pop[c]),
      .slot_out       (slot_head[c]),
      .slot_out_valid (slot_avail[c]),
      .slot_count     (slot_count[c]),
      .enq_err        ()
    );
  end

endmodule

`default_nettype wire

/* design/slot_keeper.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sched_params.svh"

module slot_keeper import sched_pkg::*; (
  input  logic  clk,
  input  logic  rst_r,
  input  logic  init_valid,
  input  slot_t init_slots,
  input  logic  slot_in_valid,
  input  slot_t slot_in,
  input  logic  slot_out_pop,
  output slot_t slot_out,
  output logic  slot_out_valid,
  output slot_t slot_count,
  output logic  enq_err
);

  localparam int PTR_WIDTH = $clog2(`SCHED_SLOT_COUNT);

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  slot_t mem [`SCHED_SLOT_COUNT];
  ptr_t  rd_ptr;
  ptr_t  wr_ptr;
  slot_t init_n;
  logic  full;
  logic  push;
  logic  pop;

  // Init never loads more than the queue holds
  assign init_n = (init_slots > slot_t'(`SCHED_SLOT_COUNT)) ?
                  slot_t'(`SCHED_SLOT_COUNT) : init_slots;

  assign full           = slot_count == slot_t'(`SCHED_SLOT_COUNT);
  assign push           = slot_in_valid && !full;
  assign pop            = slot_out_pop && slot_out_valid;
  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = slot_count != '0;

  // Init fills slots 1..N from the head; entries past N are never read
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (push) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
      enq_err    <= 1'b0;
    end else begin
      enq_err <= slot_in_valid && full;
      if (init_valid) begin
        rd_ptr     <= '0;
        wr_ptr     <= ptr_t'(init_n);
        slot_count <= init_n;
      end else begin
        if (push) wr_ptr <= wr_ptr + 1'b1;
        if (pop) rd_ptr <= rd_ptr + 1'b1;
        if (push && !pop) begin
          slot_count <= slot_count + 1'b1;
        end else if (pop && !push) begin
          slot_count <= slot_count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/sched_pkg.sv */
`default_nettype none

`include "sched_params.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;
  typedef logic [`SCHED_CORE_COUNT-1:0] core_mask_t;

  // Slot numbers run 0 to SLOT_COUNT, so one extra value is needed
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0] if_id_t;
  typedef logic [`SCHED_IF_COUNT-1:0] if_mask_t;
  typedef logic [31:0] hash_t;
  typedef logic [`SCHED_RX_LINES_WIDTH-1:0] line_count_t;
  typedef logic [31:0] host_word_t;

  // Slot message types sent by the cores
  typedef enum logic [3:0] {
    slot_release = 4'd0,
    slot_init    = 4'd3
  } slot_msg_e;

endpackage

`default_nettype wire

/* include/sched_params.svh */
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// Number of Ethernet interfaces feeding the scheduler
`define SCHED_IF_COUNT 3

// Number of receiving cores
`define SCHED_CORE_COUNT 8

// Free receive slots per core
`define SCHED_SLOT_COUNT 16

// Lowest hash bit of the destination core field
`define SCHED_HASH_SEL_OFFSET 14

// Width of a receive buffer line count
`define SCHED_RX_LINES_WIDTH 13

// Drop limit after reset, 7/8 of the receive buffer
`define SCHED_DROP_LIMIT_RESET 3584

`endif
